//--- Makefile
TOP = tb_standby_target

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_bus_driver.svh
// Bus controller tasks for START, repeated START, byte transfer with ACK sampling and STOP
`ifndef TB_BUS_DRIVER_SVH
`define TB_BUS_DRIVER_SVH

localparam int HALF = 16;

task automatic wait_cycles(input int n);
  repeat (n) begin
    @(posedge clk_i);
  end
  #2;
endtask

// SCL and SDA both high on entry
task automatic bus_start();
  drv_sda = 1'b0;
  wait_cycles(HALF);
  drv_scl = 1'b0;
  wait_cycles(HALF);
endtask

// Entered with SCL low after an ACK slot
task automatic bus_restart();
  drv_sda = 1'b1;
  wait_cycles(HALF);
  drv_scl = 1'b1;
  wait_cycles(HALF);
  bus_start();
endtask

task automatic bus_stop();
  drv_sda = 1'b0;
  wait_cycles(HALF);
  drv_scl = 1'b1;
  wait_cycles(HALF);
  drv_sda = 1'b1;
  wait_cycles(HALF);
endtask

// MSB first, then release SDA and sample the ninth bit mid-high
task automatic send_byte(input logic [7:0] b, output logic ack);
  for (int i = 7; i >= 0; i--) begin
    drv_sda = b[i];
    wait_cycles(HALF);
    drv_scl = 1'b1;
    wait_cycles(HALF);
    drv_scl = 1'b0;
  end
  drv_sda = 1'b1;
  wait_cycles(HALF);
  drv_scl = 1'b1;
  wait_cycles(HALF / 2);
  ack = ~sda_bus;
  wait_cycles(HALF / 2);
  drv_scl = 1'b0;
endtask

`endif

//--- bench/tb_standby_target.sv
// Testbench for the standby target with bus driver, reference model, queue sink and checks
`timescale 1ns/1ps
`default_nettype none

module tb_standby_target;

  localparam logic [6:0] STATIC_ADDR = 7'h51;
  localparam logic [6:0] DYN_ADDR    = 7'h2A;
  localparam int         T_FREE      = 40;
  localparam int         T_IDLE      = 150;
  localparam int         T_AVAIL     = 90;
  // Transfers, bytes per transfer, cycles per byte, then margin
  localparam int         CYC_LIMIT   = 10 * 8 * 9 * 32 * 2 + 5000;

  logic        clk_i;
  logic        reset_i;
  logic        enable_i;
  logic        drv_scl;
  logic        drv_sda;
  logic        sda_bus;
  logic [6:0]  dynamic_addr_i;
  logic        dynamic_addr_valid_i;
  logic        rx_queue_wready_i;
  logic        ctrl_scl_o;
  logic        ctrl_sda_o;
  logic        rx_queue_wvalid_o;
  logic [7:0]  rx_queue_wdata_o;
  logic        rx_queue_wflush_o;
  logic        bus_start_o;
  logic        bus_stop_o;
  logic [7:0]  bus_addr_o;
  logic        bus_addr_valid_o;
  logic        bus_busy_o;
  logic        bus_free_o;
  logic        bus_idle_o;
  logic        bus_available_o;

  logic        rand_ready;
  logic        ready_level;
  int          cyc;
  int          errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;

  logic [7:0]  tx_data[$];
  logic        exp_ack[$];
  logic [7:0]  exp_data[$];
  int          exp_flush;
  logic        got_ack[$];
  logic [7:0]  got_data[$];
  int          flush_cnt;
  int          addr_cnt;
  logic [7:0]  got_addr;
  int          start_cnt;
  int          stop_cnt;
  int          stop_cyc;
  int          free_cyc;
  int          idle_cyc;
  int          avail_cyc;
  logic        busy_before_free;
  logic        free_q;
  logic        idle_q;
  logic        avail_q;
  logic        busy_q;
  logic        start_q;

  // Open-drain bus, wired AND of controller and target
  assign sda_bus = drv_sda & ctrl_sda_o;

  standby_target_top dut0 (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .enable_i            (enable_i),
    .ctrl_scl_i          (drv_scl),
    .ctrl_sda_i          (sda_bus),
    .static_addr_i       (STATIC_ADDR),
    .dynamic_addr_i      (dynamic_addr_i),
    .dynamic_addr_valid_i(dynamic_addr_valid_i),
    .t_bus_free_i        (20'(T_FREE)),
    .t_bus_idle_i        (20'(T_IDLE)),
    .t_bus_available_i   (20'(T_AVAIL)),
    .rx_queue_wready_i   (rx_queue_wready_i),
    .ctrl_scl_o          (ctrl_scl_o),
    .ctrl_sda_o          (ctrl_sda_o),
    .rx_queue_wvalid_o   (rx_queue_wvalid_o),
    .rx_queue_wdata_o    (rx_queue_wdata_o),
    .rx_queue_wflush_o   (rx_queue_wflush_o),
    .bus_start_o         (bus_start_o),
    .bus_stop_o          (bus_stop_o),
    .bus_addr_o          (bus_addr_o),
    .bus_addr_valid_o    (bus_addr_valid_o),
    .bus_busy_o          (bus_busy_o),
    .bus_free_o          (bus_free_o),
    .bus_idle_o          (bus_idle_o),
    .bus_available_o     (bus_available_o)
  );

  `include "tb_bus_driver.svh"

  always begin
    #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles, a transfer never completed", cyc);
      $display("Something failed");
      $finish;
    end
  end

  // Ready pattern, random or held
  always @(posedge clk_i) begin
    #2;
    if (rand_ready) begin
      rx_queue_wready_i = ($urandom % 4) != 0;
    end else begin
      rx_queue_wready_i = ready_level;
    end
  end

  // Queue sink and bus event recorder
  always @(posedge clk_i) begin
    if (rx_queue_wvalid_o && rx_queue_wready_i) begin
      got_data.push_back(rx_queue_wdata_o);
    end
    if (rx_queue_wflush_o) begin
      flush_cnt++;
    end
    if (bus_addr_valid_o) begin
      addr_cnt++;
      got_addr = bus_addr_o;
    end
    if (bus_start_o) begin
      start_cnt++;
    end
    if (bus_stop_o) begin
      stop_cnt++;
      stop_cyc = cyc;
    end
    if (bus_free_o && !free_q) begin
      free_cyc = cyc;
      busy_before_free = busy_q;
    end
    if (bus_idle_o && !idle_q) begin
      idle_cyc = cyc;
    end
    if (bus_available_o && !avail_q) begin
      avail_cyc = cyc;
    end
    assert (!start_q || bus_busy_o) else begin
      $display("Mismatch at %0t ns: bus_busy_o expected 1 got 0", $time);
      errors++;
    end
    // Target never stretches the clock
    assert (ctrl_scl_o === 1'b1) else begin
      $display("Mismatch at %0t ns: ctrl_scl_o expected 1 got %b", $time, ctrl_scl_o);
      errors++;
    end
    free_q  = bus_free_o;
    idle_q  = bus_idle_o;
    avail_q = bus_available_o;
    busy_q  = bus_busy_o;
    start_q = bus_start_o;
  end

  // Expected ACKs, queue bytes and flush for one transfer
  function automatic void build_expect(input logic [7:0] ab, input logic stall);
    logic [6:0] addr;
    logic       match;
    logic       fwd;
    addr  = ab[7:1];
    match = !ab[0] && ((addr == STATIC_ADDR) || (addr == 7'h7E) ||
                       (dynamic_addr_valid_i && (addr == dynamic_addr_i)));
    fwd   = addr != 7'h7E;
    exp_ack.delete();
    exp_data.delete();
    exp_ack.push_back(match);
    if (match) begin
      for (int i = 0; i < tx_data.size(); i++) begin
        if (fwd && stall && (i > 0)) begin
          // Second byte meets a full buffer and ends the transfer
          exp_ack.push_back(1'b0);
          break;
        end
        exp_ack.push_back(1'b1);
        if (fwd) begin
          exp_data.push_back(tx_data[i]);
        end
      end
    end
    exp_flush = (exp_data.size() > 0) ? 1 : 0;
  endfunction

  task automatic check_val(input string name, input int expv, input int gotv);
    assert (expv == gotv) else begin
      $display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, expv, gotv);
      errors++;
    end
  endtask

  task automatic clear_records();
    got_ack.delete();
    got_data.delete();
    flush_cnt = 0;
    addr_cnt  = 0;
    start_cnt = 0;
    stop_cnt  = 0;
    free_cyc  = -1;
    idle_cyc  = -1;
    avail_cyc = -1;
  endtask

  // Stops sending at the first NACK
  task automatic run_transfer(input logic [7:0] ab);
    logic ack;
    bus_start();
    send_byte(ab, ack);
    got_ack.push_back(ack);
    for (int i = 0; i < tx_data.size() && ack; i++) begin
      send_byte(tx_data[i], ack);
      got_ack.push_back(ack);
    end
    bus_stop();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("Test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic run_and_check(input string name, input logic [7:0] ab, input logic stall);
    build_expect(ab, stall);
    clear_records();
    run_transfer(ab);
    if (stall) begin
      ready_level = 1'b1;
    end
    // Held byte leaves once the queue takes it
    while (rx_queue_wvalid_o) begin
      wait_cycles(1);
    end
    check_val("ack count", exp_ack.size(), got_ack.size());
    for (int i = 0; i < exp_ack.size() && i < got_ack.size(); i++) begin
      check_val($sformatf("ack[%0d]", i), int'(exp_ack[i]), int'(got_ack[i]));
    end
    check_val("rx_queue write count", exp_data.size(), got_data.size());
    for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
      check_val($sformatf("rx_queue_wdata_o[%0d]", i), int'(exp_data[i]), int'(got_data[i]));
    end
    check_val("rx_queue_wflush_o pulses", exp_flush, flush_cnt);
    check_val("bus_addr_valid_o pulses", 1, addr_cnt);
    check_val("bus_addr_o", int'(ab), int'(got_addr));
    report_test(name);
  endtask

  task automatic random_bytes(input int n);
    logic [31:0] r;
    tx_data.delete();
    for (int i = 0; i < n; i++) begin
      r = $urandom;
      tx_data.push_back(r[7:0]);
    end
  endtask

  initial begin
    logic ack;
    void'($urandom(32'h3c71c1d2));
    clk_i                = 1'b0;
    reset_i              = 1'b1;
    enable_i             = 1'b1;
    drv_scl              = 1'b1;
    drv_sda              = 1'b1;
    dynamic_addr_i       = DYN_ADDR;
    dynamic_addr_valid_i = 1'b0;
    rx_queue_wready_i    = 1'b1;
    rand_ready           = 1'b0;
    ready_level          = 1'b1;
    errors               = 0;
    err_mark             = 0;
    tests_run            = 0;
    tests_failed         = 0;
    free_q               = 1'b0;
    idle_q               = 1'b0;
    avail_q              = 1'b0;
    busy_q               = 1'b0;
    start_q              = 1'b0;
    busy_before_free     = 1'b0;
    clear_records();
    repeat (10) begin
      @(posedge clk_i);
    end
    #2;
    reset_i = 1'b0;
    wait_cycles(20);

    rand_ready = 1'b1;
    random_bytes(6);
    run_and_check("static write", {STATIC_ADDR, 1'b0}, 1'b0);

    random_bytes(2);
    run_and_check("other address", {7'h33, 1'b0}, 1'b0);
    run_and_check("read to static", {STATIC_ADDR, 1'b1}, 1'b0);

    random_bytes(3);
    run_and_check("dynamic not valid", {DYN_ADDR, 1'b0}, 1'b0);
    dynamic_addr_valid_i = 1'b1;
    run_and_check("dynamic valid", {DYN_ADDR, 1'b0}, 1'b0);
    run_and_check("broadcast", {7'h7E, 1'b0}, 1'b0);

    rand_ready  = 1'b0;
    ready_level = 1'b0;
    wait_cycles(2);
    random_bytes(3);
    run_and_check("back-pressure", {STATIC_ADDR, 1'b0}, 1'b1);

    // Write, repeated START to another address, STOP, then the timers
    ready_level = 1'b1;
    random_bytes(1);
    clear_records();
    bus_start();
    send_byte({STATIC_ADDR, 1'b0}, ack);
    send_byte(tx_data[0], ack);
    bus_restart();
    send_byte({7'h33, 1'b0}, ack);
    bus_stop();
    wait_cycles(T_IDLE + 20);
    check_val("bus_start_o pulses", 2, start_cnt);
    check_val("bus_stop_o pulses", 1, stop_cnt);
    check_val("bus_free_o delay", T_FREE, free_cyc - stop_cyc);
    check_val("bus_idle_o delay", T_IDLE, idle_cyc - stop_cyc);
    check_val("bus_available_o delay", T_AVAIL, avail_cyc - stop_cyc);
    check_val("bus_busy_o before free", 1, int'(busy_before_free));
    check_val("bus_busy_o after free", 0, int'(bus_busy_o));
    report_test("bus conditions");

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
logic/standby_pkg.sv
logic/bus_events_if.sv
logic/bus_monitor.sv
logic/bus_timer.sv
logic/bus_state.sv
logic/target_fsm.sv
logic/rx_flow.sv
logic/standby_target_top.sv
bench/tb_standby_target.sv

//--- logic/bus_events_if.sv
// Synchronized SCL/SDA levels and bus edge events, monitor to target FSM
`timescale 1ns/1ps
`default_nettype none

interface bus_events_if;

  // Levels aligned with the event pulses
  logic scl;
  logic sda;

  // One-cycle pulses
  logic scl_rise;
  logic scl_fall;
  logic start;
  logic stop;

  modport monitor (output scl, sda, scl_rise, scl_fall, start, stop);

  modport target (input scl, sda, scl_rise, scl_fall, start, stop);

endinterface

`default_nettype wire

//--- logic/bus_monitor.sv
// Bus monitor with SCL/SDA synchronizers, SCL edges and START/STOP detection
`timescale 1ns/1ps
`default_nettype none

module bus_monitor (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          enable_i,
  input  logic          scl_i,
  input  logic          sda_i,
  bus_events_if.monitor ev
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_s;
  logic       sda_s;

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // Two-flop synchronizers, then the previous-value register
  // An idle bus has both lines released
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      ev.scl     <= 1'b1;
      ev.sda     <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      ev.scl     <= scl_s;
      ev.sda     <= sda_s;
    end
  end

  // Edge register, events compare new sample against previous
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ev.scl_rise <= 1'b0;
      ev.scl_fall <= 1'b0;
      ev.start    <= 1'b0;
      ev.stop     <= 1'b0;
    end else if (!enable_i) begin
      ev.scl_rise <= 1'b0;
      ev.scl_fall <= 1'b0;
      ev.start    <= 1'b0;
      ev.stop     <= 1'b0;
    end else begin
      ev.scl_rise <= scl_s & ~ev.scl;
      ev.scl_fall <= ~scl_s & ev.scl;
      // SDA edges while SCL stays high
      ev.start    <= scl_s & ev.scl & ev.sda & ~sda_s;
      ev.stop     <= scl_s & ev.scl & ~ev.sda & sda_s;
    end
  end

endmodule

`default_nettype wire

//--- logic/bus_state.sv
// Bus status tracker with busy flag and free, idle and available levels
`timescale 1ns/1ps
`default_nettype none

module bus_state (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   start_i,
  input  logic [standby_pkg::NUM_BUS_TIMERS-1:0] expired_i,
  output logic                                   bus_busy_o,
  output logic                                   bus_free_o,
  output logic                                   bus_idle_o,
  output logic                                   bus_available_o
);

  logic free_hit;
  logic idle_hit;
  logic avail_hit;

  // START drops every level in the cycle it arrives
  assign free_hit  = expired_i[standby_pkg::TIMER_FREE] & ~start_i;
  assign idle_hit  = expired_i[standby_pkg::TIMER_IDLE] & ~start_i;

  // Available implies free
  assign avail_hit = expired_i[standby_pkg::TIMER_AVAIL] & free_hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus_busy_o      <= 1'b0;
      bus_free_o      <= 1'b0;
      bus_idle_o      <= 1'b0;
      bus_available_o <= 1'b0;
    end else begin
      if (start_i) begin
        bus_busy_o <= 1'b1;
      end else if (free_hit) begin
        bus_busy_o <= 1'b0;
      end
      bus_free_o      <= free_hit;
      bus_idle_o      <= idle_hit;
      bus_available_o <= avail_hit;
    end
  end

endmodule

`default_nettype wire

//--- logic/bus_timer.sv
// Restartable saturating bus-condition counter with threshold compare
`timescale 1ns/1ps
`default_nettype none

module bus_timer #(
  parameter int unsigned TimerWidth = 20
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  restart_i,
  input  logic                  clear_i,
  input  logic [TimerWidth-1:0] threshold_i,
  output logic                  expired_o
);

  // Restart cycle and the status register behind us both count
  localparam logic [TimerWidth:0] Lead = 2;

  logic                  running_q;
  logic [TimerWidth-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (clear_i) begin
      running_q <= 1'b0;
    end else if (restart_i) begin
      running_q <= 1'b1;
      count_q   <= '0;
    end else if (running_q && (count_q != '1)) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Count never decreases while running, so the level holds
  assign expired_o = running_q && (({1'b0, count_q} + Lead) >= {1'b0, threshold_i});

endmodule

`default_nettype wire

//--- logic/rx_flow.sv
// RX flow with one-byte holding buffer, queue write strobe and STOP flush
`timescale 1ns/1ps
`default_nettype none

module rx_flow (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    byte_valid_i,
  input  standby_pkg::addr_byte_u byte_i,
  input  logic                    stop_i,
  input  logic                    rx_queue_wready_i,
  output logic                    buffer_free_o,
  output logic                    rx_queue_wvalid_o,
  output logic [7:0]              rx_queue_wdata_o,
  output logic                    rx_queue_wflush_o
);

  logic       buf_valid_q;
  logic [7:0] buf_data_q;
  logic       wrote_q;
  logic       flush_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_valid_q <= 1'b0;
      wrote_q     <= 1'b0;
      flush_q     <= 1'b0;
    end else begin
      // A byte only arrives into an empty buffer
      if (byte_valid_i) begin
        buf_valid_q <= 1'b1;
      end else if (rx_queue_wready_i) begin
        buf_valid_q <= 1'b0;
      end
      // Transfer bookkeeping for the flush
      if (stop_i) begin
        wrote_q <= 1'b0;
      end else if (byte_valid_i) begin
        wrote_q <= 1'b1;
      end
      flush_q <= stop_i && (wrote_q || byte_valid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      buf_data_q <= byte_i.data;
    end
  end

  assign buffer_free_o     = ~buf_valid_q;
  assign rx_queue_wvalid_o = buf_valid_q;
  assign rx_queue_wdata_o  = buf_data_q;
  assign rx_queue_wflush_o = flush_q;

endmodule

`default_nettype wire

//--- logic/standby_pkg.sv
// Bus constants, timer bank indices and the received-word union
`default_nettype none

package standby_pkg;

  // I3C broadcast address, ACKed for writes
  localparam logic [6:0] BROADCAST_ADDR = 7'h7E;

  // Bus-condition timer bank
  localparam int unsigned NUM_BUS_TIMERS = 3;

  localparam int unsigned TIMER_FREE  = 0;
  localparam int unsigned TIMER_IDLE  = 1;
  localparam int unsigned TIMER_AVAIL = 2;

  // One word off the bus, MSB first
  // Address phase reads the addr_view, data phase reads the raw byte
  typedef union packed {
    logic [7:0] data;
    struct packed {
      logic [6:0] addr;
      logic       rnw;
    } addr_view;
  } addr_byte_u;

endpackage

`default_nettype wire

//--- logic/standby_target_top.sv
// Standby target top with bus monitor, timer bank, bus tracker, FSM and RX flow
`timescale 1ns/1ps
`default_nettype none

module standby_target_top #(
  parameter int unsigned TimerWidth = 20
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  enable_i,
  input  logic                  ctrl_scl_i,
  input  logic                  ctrl_sda_i,
  input  logic [6:0]            static_addr_i,
  input  logic [6:0]            dynamic_addr_i,
  input  logic                  dynamic_addr_valid_i,
  input  logic [TimerWidth-1:0] t_bus_free_i,
  input  logic [TimerWidth-1:0] t_bus_idle_i,
  input  logic [TimerWidth-1:0] t_bus_available_i,
  input  logic                  rx_queue_wready_i,
  output logic                  ctrl_scl_o,
  output logic                  ctrl_sda_o,
  output logic                  rx_queue_wvalid_o,
  output logic [7:0]            rx_queue_wdata_o,
  output logic                  rx_queue_wflush_o,
  output logic                  bus_start_o,
  output logic                  bus_stop_o,
  output logic [7:0]            bus_addr_o,
  output logic                  bus_addr_valid_o,
  output logic                  bus_busy_o,
  output logic                  bus_free_o,
  output logic                  bus_idle_o,
  output logic                  bus_available_o
);

  bus_events_if ev ();

  logic [TimerWidth-1:0]                  threshold [standby_pkg::NUM_BUS_TIMERS];
  logic [standby_pkg::NUM_BUS_TIMERS-1:0] expired;
  logic                                   byte_valid;
  standby_pkg::addr_byte_u                rx_byte;
  logic                                   buffer_free;

  assign threshold[standby_pkg::TIMER_FREE]  = t_bus_free_i;
  assign threshold[standby_pkg::TIMER_IDLE]  = t_bus_idle_i;
  assign threshold[standby_pkg::TIMER_AVAIL] = t_bus_available_i;

  bus_monitor xbus_monitor (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .enable_i(enable_i),
    .scl_i   (ctrl_scl_i),
    .sda_i   (ctrl_sda_i),
    .ev      (ev)
  );

  // STOP starts every timer, START stops them
  for (genvar i = 0; i < standby_pkg::NUM_BUS_TIMERS; i++) begin : g_timer
    bus_timer #(
      .TimerWidth(TimerWidth)
    ) xbus_timer (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .restart_i  (ev.stop),
      .clear_i    (ev.start),
      .threshold_i(threshold[i]),
      .expired_o  (expired[i])
    );
  end

  bus_state xbus_state (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .start_i        (ev.start),
    .expired_i      (expired),
    .bus_busy_o     (bus_busy_o),
    .bus_free_o     (bus_free_o),
    .bus_idle_o     (bus_idle_o),
    .bus_available_o(bus_available_o)
  );

  target_fsm xtarget_fsm (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .enable_i            (enable_i),
    .static_addr_i       (static_addr_i),
    .dynamic_addr_i      (dynamic_addr_i),
    .dynamic_addr_valid_i(dynamic_addr_valid_i),
    .ev                  (ev),
    .sda_o               (ctrl_sda_o),
    .byte_valid_o        (byte_valid),
    .byte_o              (rx_byte),
    .buffer_free_i       (buffer_free),
    .bus_addr_o          (bus_addr_o),
    .bus_addr_valid_o    (bus_addr_valid_o)
  );

  rx_flow xrx_flow (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .byte_valid_i     (byte_valid),
    .byte_i           (rx_byte),
    .stop_i           (ev.stop),
    .rx_queue_wready_i(rx_queue_wready_i),
    .buffer_free_o    (buffer_free),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .rx_queue_wflush_o(rx_queue_wflush_o)
  );

  // No clock stretching
  assign ctrl_scl_o  = 1'b1;

  assign bus_start_o = ev.start;
  assign bus_stop_o  = ev.stop;

endmodule

`default_nettype wire

//--- logic/target_fsm.sv
// Target FSM with bit shifter, address match, ACK/NACK drive and data bytes
`timescale 1ns/1ps
`default_nettype none

module target_fsm (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    enable_i,
  input  logic [6:0]              static_addr_i,
  input  logic [6:0]              dynamic_addr_i,
  input  logic                    dynamic_addr_valid_i,
  bus_events_if.target            ev,
  output logic                    sda_o,
  output logic                    byte_valid_o,
  output standby_pkg::addr_byte_u byte_o,
  input  logic                    buffer_free_i,
  output logic [7:0]              bus_addr_o,
  output logic                    bus_addr_valid_o
);

  localparam logic [2:0] StIdle    = 3'd0;
  localparam logic [2:0] StAddr    = 3'd1;
  localparam logic [2:0] StAddrAck = 3'd2;
  localparam logic [2:0] StData    = 3'd3;
  localparam logic [2:0] StDataAck = 3'd4;
  localparam logic [2:0] StIgnore  = 3'd5;

  logic [2:0]              state_q;
  logic [2:0]              bit_cnt_q;
  standby_pkg::addr_byte_u shift_q;
  standby_pkg::addr_byte_u next_word;
  logic                    last_bit;
  logic                    addr_ack;
  logic                    ack_q;
  logic                    slot_q;
  logic                    forward_q;
  logic                    sda_q;
  logic                    addr_valid_q;
  logic [7:0]              addr_q;

  // Word as it stands once this SCL rise is sampled
  assign next_word = {shift_q.data[6:0], ev.sda};
  assign last_bit  = ev.scl_rise && (bit_cnt_q == 3'd7);

  // Writes only, reads are not served
  assign addr_ack = !next_word.addr_view.rnw &&
                    ((next_word.addr_view.addr == static_addr_i) ||
                     (dynamic_addr_valid_i && (next_word.addr_view.addr == dynamic_addr_i)) ||
                     (next_word.addr_view.addr == standby_pkg::BROADCAST_ADDR));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= StIdle;
      bit_cnt_q    <= 3'd0;
      ack_q        <= 1'b0;
      slot_q       <= 1'b0;
      forward_q    <= 1'b0;
      sda_q        <= 1'b1;
      addr_valid_q <= 1'b0;
    end else begin
      addr_valid_q <= 1'b0;
      if (!enable_i || ev.stop) begin
        state_q <= StIdle;
        slot_q  <= 1'b0;
        sda_q   <= 1'b1;
      end else if (ev.start) begin
        // Repeated START lands here too
        state_q   <= StAddr;
        bit_cnt_q <= 3'd0;
        slot_q    <= 1'b0;
        sda_q     <= 1'b1;
      end else begin
        case (state_q)
          StAddr: begin
            if (ev.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (last_bit) begin
                addr_valid_q <= 1'b1;
                ack_q        <= addr_ack;
                forward_q    <= next_word.addr_view.addr != standby_pkg::BROADCAST_ADDR;
                state_q      <= StAddrAck;
              end
            end
          end
          StData: begin
            if (ev.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (last_bit) begin
                // Full buffer means the byte is dropped
                ack_q   <= buffer_free_i || !forward_q;
                state_q <= StDataAck;
              end
            end
          end
          StAddrAck, StDataAck: begin
            // First fall opens the ACK slot, second closes it
            if (ev.scl_fall) begin
              if (!slot_q) begin
                slot_q <= 1'b1;
                sda_q  <= ~ack_q;
              end else begin
                slot_q  <= 1'b0;
                sda_q   <= 1'b1;
                state_q <= ack_q ? StData : StIgnore;
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Shifter and captured address
  always_ff @(posedge clk_i) begin
    if (ev.scl_rise && ((state_q == StAddr) || (state_q == StData))) begin
      shift_q <= next_word;
    end
    if ((state_q == StAddr) && last_bit) begin
      addr_q <= next_word.data;
    end
  end

  assign byte_valid_o     = (state_q == StData) && last_bit && forward_q && buffer_free_i;
  assign byte_o           = next_word;
  assign sda_o            = sda_q;
  assign bus_addr_o       = addr_q;
  assign bus_addr_valid_o = addr_valid_q;

endmodule

`default_nettype wire
